//--- include/csr_params.svh
// widths and trap causes shared by the csr unit
// only machine mode causes are defined, no interrupt codes
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

// data path width
`define CSR_XLEN 64

// csr address field of the instruction
`define CSR_ADDR_W 12

// rs1 field, also the zimm of the immediate forms
`define CSR_ZIMM_W 5

// mcause values for synchronous traps
// environment call from machine mode
`define CSR_CAUSE_ECALL_M 11

// ebreak
`define CSR_CAUSE_BREAKPOINT 3

// illegal instruction, used for unknown csr addresses
`define CSR_CAUSE_ILLEGAL 2

`endif

//--- run_sim.sh
#!/usr/bin/env bash
# builds the csr unit testbench with verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    --top-module csr_unit_tb -f src.f -Mdir obj_dir \
    || { echo "build failed"; exit 1; }

out="$(./obj_dir/Vcsr_unit_tb)"
echo "$out"

echo "$out" | grep -qx "NO ERRORS" && exit 0 || exit 1

//--- source/csr_counters.sv
// mcycle and minstret, free running, a software write wins over the increment
`include "csr_params.svh"

module csr_counters (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  csr_pkg::csr_wr_t     wr_i,
    input  logic                 retire_i,
    output logic [`CSR_XLEN-1:0] mcycle_o,
    output logic [`CSR_XLEN-1:0] minstret_o
);

    import csr_pkg::*;

    // index 0 is mcycle, 1 is minstret
    logic [`CSR_XLEN-1:0] cnt_q [2];
    logic [1:0]           inc;
    logic [1:0]           sw_wr;
    csr_addr_t            cnt_addr [2];

    assign cnt_addr[0] = CSR_MCYCLE;
    assign cnt_addr[1] = CSR_MINSTRET;

    // mcycle every cycle, minstret on retire
    assign inc = {retire_i, 1'b1};

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < 2; i++) begin
            if (!rst_n_i) begin
                cnt_q[i] <= '0;
            end else if (sw_wr[i]) begin
                cnt_q[i] <= csr_apply(cnt_q[i], wr_i.cmd, wr_i.data);
            end else if (inc[i]) begin
                cnt_q[i] <= cnt_q[i] + 1'b1;
            end
        end
    end

    // write hits the counter's own address only
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            sw_wr[i] = wr_i.wr_en && (wr_i.addr == cnt_addr[i]);
        end
    end

    assign mcycle_o   = cnt_q[0];
    assign minstret_o = cnt_q[1];

endmodule

//--- source/csr_ctrl.sv
// csr control, purely combinational, picks write, trap or mret for one instruction
// redirect and illegal show the decode even under stall, state updates do not
`include "csr_params.svh"

module csr_ctrl (
    input  logic                       csr_ena_i,
    input  csr_pkg::req_cpu_csr_t      req_i,
    input  csr_pkg::instr_type_t       instr_type_i,
    input  logic                       stall_i,
    // from the register file
    input  logic                       addr_hit_i,
    input  logic [`CSR_XLEN-1:0]       mepc_i,
    input  logic [`CSR_XLEN-1:0]       mtvec_i,
    // state updates
    output csr_pkg::csr_wr_t           wr_o,
    output csr_pkg::trap_t             trap_o,
    output logic                       mret_o,
    output logic                       retire_o,
    // to the core
    output csr_pkg::redirect_t         redirect_o,
    output logic                       illegal_o
);

    import csr_pkg::*;

    logic                 is_access;
    logic                 is_write;
    logic                 is_sys;
    logic                 illegal;
    logic                 is_env;
    logic                 is_mret;
    logic                 trap_any;
    logic [`CSR_XLEN-1:0] trap_cause;

    // real csr accesses, system kinds excluded
    assign is_access = csr_ena_i &&
                       (req_i.csr_rw_cmd inside {CSR_CMD_READ, CSR_CMD_WRITE,
                                                 CSR_CMD_SET, CSR_CMD_CLEAR});
    assign is_write  = req_i.csr_rw_cmd inside {CSR_CMD_WRITE, CSR_CMD_SET, CSR_CMD_CLEAR};
    assign is_sys    = csr_ena_i && (req_i.csr_rw_cmd == CSR_CMD_SYS);

    // unknown address, read included
    assign illegal = is_access && !addr_hit_i;
    assign is_env  = is_sys && (instr_type_i inside {ECALL, EBREAK});

    // an incoming exception overrides mret
    assign is_mret  = is_sys && (instr_type_i == MRET) && !req_i.csr_exception;
    assign trap_any = req_i.csr_exception || illegal || is_env;

    // cause priority: pipeline exception, illegal, ecall or ebreak
    always_comb begin
        if (req_i.csr_exception) begin
            trap_cause = req_i.csr_xcpt_cause;
        end else if (illegal) begin
            trap_cause = `CSR_XLEN'(`CSR_CAUSE_ILLEGAL);
        end else if (instr_type_i == ECALL) begin
            trap_cause = `CSR_XLEN'(`CSR_CAUSE_ECALL_M);
        end else begin
            trap_cause = `CSR_XLEN'(`CSR_CAUSE_BREAKPOINT);
        end
    end

    // write only when legal, clean and not stalled
    assign wr_o.wr_en = is_access && is_write && addr_hit_i &&
                        !req_i.csr_exception && !stall_i;
    assign wr_o.cmd   = req_i.csr_rw_cmd;
    assign wr_o.addr  = req_i.csr_rw_addr;
    assign wr_o.data  = req_i.csr_rw_data;

    assign trap_o.take  = trap_any && !stall_i;
    assign trap_o.cause = trap_cause;
    assign trap_o.epc   = req_i.csr_pc;

    assign mret_o = is_mret && !stall_i;

    // ecall, ebreak and illegal accesses do not retire
    assign retire_o = req_i.csr_retire && !trap_any;

    // trap goes to mtvec, mret back to mepc
    assign redirect_o.valid = trap_any || is_mret;
    assign redirect_o.pc    = trap_any ? mtvec_i : mepc_i;

    // flagged only when illegal is the chosen cause
    assign illegal_o = illegal && !req_i.csr_exception;

endmodule

//--- source/csr_interface.sv
// decodes the writeback instruction into a csr request, purely combinational
// wb_xcpt_i is passed through as is, it is not qualified here
`include "csr_params.svh"

module csr_interface (
    // writeback side
    input  logic                   wb_xcpt_i,
    input  csr_pkg::exe_wb_instr_t exe_to_wb_wb_i,
    input  logic                   stall_exe_i,
    // csr or system instruction present
    output logic                   wb_csr_ena_int_o,
    // request towards the csr control
    output csr_pkg::req_cpu_csr_t  req_cpu_csr_o
);

    import csr_pkg::*;

    logic                 csr_ena;
    csr_cmd_t             csr_cmd;
    logic [`CSR_XLEN-1:0] csr_wdata;
    logic [`CSR_XLEN-1:0] zimm;
    logic                 rs1_zero;
    logic                 imm_form;

    // zero extended rs1 field for the immediate forms
    assign zimm = {{(`CSR_XLEN-`CSR_ZIMM_W){1'b0}}, exe_to_wb_wb_i.rs1};
    assign rs1_zero = (exe_to_wb_wb_i.rs1 == '0);
    assign imm_form = exe_to_wb_wb_i.instr_type inside {CSRRWI, CSRRSI, CSRRCI};

    always_comb begin
        csr_cmd = CSR_CMD_NOPE;
        csr_ena = 1'b0;
        if (exe_to_wb_wb_i.valid) begin
            case (exe_to_wb_wb_i.instr_type)
                CSRRW, CSRRWI: begin
                    csr_cmd = CSR_CMD_WRITE;
                    csr_ena = 1'b1;
                end
                // x0 or zimm 0 means read only, no write side effect
                CSRRS, CSRRSI: begin
                    csr_cmd = rs1_zero ? CSR_CMD_READ : CSR_CMD_SET;
                    csr_ena = 1'b1;
                end
                CSRRC, CSRRCI: begin
                    csr_cmd = rs1_zero ? CSR_CMD_READ : CSR_CMD_CLEAR;
                    csr_ena = 1'b1;
                end
                // system kinds, only some of them act further down
                ECALL, EBREAK, MRET, WFI, URET, SRET, SFENCE_VMA, MRTS: begin
                    csr_cmd = CSR_CMD_SYS;
                    csr_ena = 1'b1;
                end
                default: begin
                    csr_cmd = CSR_CMD_NOPE;
                    csr_ena = 1'b0;
                end
            endcase
        end
    end

    // write data, none for system kinds
    always_comb begin
        if (csr_cmd == CSR_CMD_SYS) begin
            csr_wdata = '0;
        end else if (imm_form) begin
            csr_wdata = zimm;
        end else begin
            csr_wdata = exe_to_wb_wb_i.result;
        end
    end

    // disabled request carries nope, addr zero and the faulting origin
    assign req_cpu_csr_o.csr_rw_addr = csr_ena ? exe_to_wb_wb_i.csr_addr : '0;
    assign req_cpu_csr_o.csr_rw_cmd  = csr_ena ? csr_cmd : CSR_CMD_NOPE;
    assign req_cpu_csr_o.csr_rw_data = csr_ena ? csr_wdata : exe_to_wb_wb_i.ex.origin;

    // exception info straight through
    assign req_cpu_csr_o.csr_exception  = wb_xcpt_i;
    assign req_cpu_csr_o.csr_xcpt_cause = exe_to_wb_wb_i.ex.cause;
    assign req_cpu_csr_o.csr_pc         = exe_to_wb_wb_i.pc;

    // retire only a valid, clean, unstalled instruction
    assign req_cpu_csr_o.csr_retire = exe_to_wb_wb_i.valid & ~wb_xcpt_i & ~stall_exe_i;

    assign wb_csr_ena_int_o = csr_ena;

endmodule

//--- source/csr_pkg.sv
// types of the machine mode csr unit
// widths come from csr_params.svh, no virtual memory or privilege types
`include "csr_params.svh"

package csr_pkg;

    // writeback instruction kinds seen by the csr unit
    typedef enum logic [3:0] {
        CSRRW,
        CSRRS,
        CSRRC,
        CSRRWI,
        CSRRSI,
        CSRRCI,
        ECALL,
        EBREAK,
        MRET,
        WFI,
        URET,
        SRET,
        SFENCE_VMA,
        MRTS,
        OTHER
    } instr_type_t;

    // command sent with each request
    typedef enum logic [2:0] {
        CSR_CMD_NOPE,
        CSR_CMD_READ,
        CSR_CMD_WRITE,
        CSR_CMD_SET,
        CSR_CMD_CLEAR,
        CSR_CMD_SYS
    } csr_cmd_t;

    // implemented csr addresses
    typedef enum logic [`CSR_ADDR_W-1:0] {
        CSR_MSTATUS  = 12'h300,
        CSR_MTVEC    = 12'h305,
        CSR_MSCRATCH = 12'h340,
        CSR_MEPC     = 12'h341,
        CSR_MCAUSE   = 12'h342,
        CSR_MCYCLE   = 12'hB00,
        CSR_MINSTRET = 12'hB02
    } csr_addr_t;

    // exception info carried down the pipe
    typedef struct packed {
        logic [`CSR_XLEN-1:0] cause;
        logic [`CSR_XLEN-1:0] origin;
    } xcpt_t;

    // instruction at writeback
    typedef struct packed {
        logic                   valid;
        logic [`CSR_XLEN-1:0]   pc;
        instr_type_t            instr_type;
        logic [`CSR_ZIMM_W-1:0] rs1;
        logic [`CSR_ADDR_W-1:0] csr_addr;
        // rs1 register value
        logic [`CSR_XLEN-1:0]   result;
        xcpt_t                  ex;
    } exe_wb_instr_t;

    // request from the core side
    typedef struct packed {
        logic [`CSR_ADDR_W-1:0] csr_rw_addr;
        csr_cmd_t               csr_rw_cmd;
        logic [`CSR_XLEN-1:0]   csr_rw_data;
        logic                   csr_exception;
        logic                   csr_retire;
        logic [`CSR_XLEN-1:0]   csr_xcpt_cause;
        logic [`CSR_XLEN-1:0]   csr_pc;
    } req_cpu_csr_t;

    // gated software write, shared by regfile and counters
    typedef struct packed {
        logic                   wr_en;
        csr_cmd_t               cmd;
        logic [`CSR_ADDR_W-1:0] addr;
        logic [`CSR_XLEN-1:0]   data;
    } csr_wr_t;

    typedef struct packed {
        logic                 take;
        logic [`CSR_XLEN-1:0] cause;
        logic [`CSR_XLEN-1:0] epc;
    } trap_t;

    typedef struct packed {
        logic                 valid;
        logic [`CSR_XLEN-1:0] pc;
    } redirect_t;

    // new value of a csr after write, set or clear
    function automatic logic [`CSR_XLEN-1:0] csr_apply(
        input logic [`CSR_XLEN-1:0] old_val,
        input csr_cmd_t             cmd,
        input logic [`CSR_XLEN-1:0] wdata
    );
        case (cmd)
            CSR_CMD_WRITE: return wdata;
            CSR_CMD_SET:   return old_val | wdata;
            CSR_CMD_CLEAR: return old_val & ~wdata;
            default:       return old_val;
        endcase
    endfunction

endpackage

//--- source/csr_regfile.sv
// machine mode csr storage, mstatus keeps only mie and mpie
// mtvec is direct mode only, the two low bits always read zero
`include "csr_params.svh"

module csr_regfile (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic [`CSR_ADDR_W-1:0] rd_addr_i,
    input  csr_pkg::csr_wr_t       wr_i,
    input  csr_pkg::trap_t         trap_i,
    input  logic                   mret_i,
    // counter values for the read mux
    input  logic [`CSR_XLEN-1:0]   mcycle_i,
    input  logic [`CSR_XLEN-1:0]   minstret_i,
    output logic [`CSR_XLEN-1:0]   rdata_o,
    output logic                   addr_hit_o,
    output logic [`CSR_XLEN-1:0]   mepc_o,
    output logic [`CSR_XLEN-1:0]   mtvec_o
);

    import csr_pkg::*;

    // mstatus bit positions
    localparam int MIE_BIT  = 3;
    localparam int MPIE_BIT = 7;

    logic                 mie_q;
    logic                 mpie_q;
    logic [`CSR_XLEN-1:0] mtvec_q;
    logic [`CSR_XLEN-1:0] mepc_q;
    logic [`CSR_XLEN-1:0] mcause_q;
    logic [`CSR_XLEN-1:0] mscratch_q;
    logic [`CSR_XLEN-1:0] mstatus_rd;
    logic [`CSR_XLEN-1:0] wr_old;
    logic [`CSR_XLEN-1:0] wr_new;
    logic                 wr_hit;

    always_comb begin
        mstatus_rd = '0;
        mstatus_rd[MIE_BIT]  = mie_q;
        mstatus_rd[MPIE_BIT] = mpie_q;
    end

    // current value and hit for one address
    function automatic logic [`CSR_XLEN:0] lookup(input logic [`CSR_ADDR_W-1:0] addr);
        case (addr)
            CSR_MSTATUS:  return {1'b1, mstatus_rd};
            CSR_MTVEC:    return {1'b1, mtvec_q};
            CSR_MSCRATCH: return {1'b1, mscratch_q};
            CSR_MEPC:     return {1'b1, mepc_q};
            CSR_MCAUSE:   return {1'b1, mcause_q};
            CSR_MCYCLE:   return {1'b1, mcycle_i};
            CSR_MINSTRET: return {1'b1, minstret_i};
            default:      return '0;
        endcase
    endfunction

    // read port, value before this cycle's update
    always_comb begin
        {addr_hit_o, rdata_o} = lookup(rd_addr_i);
    end

    // old value for read-modify-write
    always_comb begin
        {wr_hit, wr_old} = lookup(wr_i.addr);
    end
    assign wr_new = csr_apply(wr_old, wr_i.cmd, wr_i.data);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mie_q      <= 1'b0;
            mpie_q     <= 1'b0;
            mtvec_q    <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mscratch_q <= '0;
        end else if (trap_i.take) begin
            // trap entry, stack mie
            mepc_q   <= trap_i.epc;
            mcause_q <= trap_i.cause;
            mpie_q   <= mie_q;
            mie_q    <= 1'b0;
        end else if (mret_i) begin
            // return, pop mie
            mie_q  <= mpie_q;
            mpie_q <= 1'b1;
        end else if (wr_i.wr_en && wr_hit) begin
            case (wr_i.addr)
                CSR_MSTATUS: begin
                    mie_q  <= wr_new[MIE_BIT];
                    mpie_q <= wr_new[MPIE_BIT];
                end
                CSR_MTVEC:    mtvec_q    <= {wr_new[`CSR_XLEN-1:2], 2'b00};
                CSR_MSCRATCH: mscratch_q <= wr_new;
                CSR_MEPC:     mepc_q     <= wr_new;
                CSR_MCAUSE:   mcause_q   <= wr_new;
                // counters are written in csr_counters
                default: begin
                end
            endcase
        end
    end

    assign mepc_o  = mepc_q;
    assign mtvec_o = mtvec_q;

endmodule

//--- source/csr_unit_top.sv
// machine mode csr unit at writeback, read data and redirect are combinational
// updates land on the next rising edge, no interrupts
`include "csr_params.svh"

module csr_unit_top (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  csr_pkg::exe_wb_instr_t wb_i,
    input  logic                   wb_xcpt_i,
    input  logic                   stall_exe_i,
    output logic [`CSR_XLEN-1:0]   csr_rdata_o,
    output csr_pkg::redirect_t     redirect_o,
    output logic                   illegal_o,
    output csr_pkg::req_cpu_csr_t  csr_req_o
);

    import csr_pkg::*;

    req_cpu_csr_t         req;
    logic                 csr_ena;
    csr_wr_t              wr;
    trap_t                trap;
    logic                 mret;
    logic                 retire;
    logic                 addr_hit;
    logic [`CSR_XLEN-1:0] mepc;
    logic [`CSR_XLEN-1:0] mtvec;
    logic [`CSR_XLEN-1:0] mcycle;
    logic [`CSR_XLEN-1:0] minstret;

    // decode
    csr_interface u_interface (
        .wb_xcpt_i        (wb_xcpt_i),
        .exe_to_wb_wb_i   (wb_i),
        .stall_exe_i      (stall_exe_i),
        .wb_csr_ena_int_o (csr_ena),
        .req_cpu_csr_o    (req)
    );

    // legality, trap and return
    csr_ctrl u_ctrl (
        .csr_ena_i    (csr_ena),
        .req_i        (req),
        .instr_type_i (wb_i.instr_type),
        .stall_i      (stall_exe_i),
        .addr_hit_i   (addr_hit),
        .mepc_i       (mepc),
        .mtvec_i      (mtvec),
        .wr_o         (wr),
        .trap_o       (trap),
        .mret_o       (mret),
        .retire_o     (retire),
        .redirect_o   (redirect_o),
        .illegal_o    (illegal_o)
    );

    // read address is the request address
    csr_regfile u_regfile (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rd_addr_i  (req.csr_rw_addr),
        .wr_i       (wr),
        .trap_i     (trap),
        .mret_i     (mret),
        .mcycle_i   (mcycle),
        .minstret_i (minstret),
        .rdata_o    (csr_rdata_o),
        .addr_hit_o (addr_hit),
        .mepc_o     (mepc),
        .mtvec_o    (mtvec)
    );

    csr_counters u_counters (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .wr_i       (wr),
        .retire_i   (retire),
        .mcycle_o   (mcycle),
        .minstret_o (minstret)
    );

    assign csr_req_o = req;

endmodule

//--- src.f
+incdir+include
source/csr_pkg.sv
source/csr_interface.sv
source/csr_ctrl.sv
source/csr_regfile.sv
source/csr_counters.sv
source/csr_unit_top.sv
verif/csr_unit_tb.sv

//--- verif/csr_unit_tb.sv
// self-checking testbench for csr_unit_top, model stepped once per cycle at the falling edge
// the redirect pc is only compared when a redirect is expected
`include "csr_params.svh"

module csr_unit_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import csr_pkg::*;

    localparam int N_DIRECTED = 32;
    localparam int N_RANDOM   = 400;
    localparam int N_INSTR    = N_DIRECTED + N_RANDOM;

    // architectural state as the model sees it
    typedef struct packed {
        logic                 mie;
        logic                 mpie;
        logic [`CSR_XLEN-1:0] mtvec;
        logic [`CSR_XLEN-1:0] mepc;
        logic [`CSR_XLEN-1:0] mcause;
        logic [`CSR_XLEN-1:0] mscratch;
        logic [`CSR_XLEN-1:0] mcycle;
        logic [`CSR_XLEN-1:0] minstret;
    } model_t;

    // combinational outputs expected in the current cycle
    typedef struct packed {
        logic [`CSR_XLEN-1:0] rdata;
        logic                 redir_valid;
        logic [`CSR_XLEN-1:0] redir_pc;
        logic                 illegal;
        req_cpu_csr_t         req;
    } expect_t;

    logic                 clk_i;
    logic                 rst_n_i;
    exe_wb_instr_t        wb_i;
    logic                 wb_xcpt_i;
    logic                 stall_exe_i;
    logic [`CSR_XLEN-1:0] csr_rdata_o;
    redirect_t            redirect_o;
    logic                 illegal_o;
    req_cpu_csr_t         csr_req_o;

    model_t               model_q;
    model_t               model_nxt;
    expect_t              exp_s;
    logic [`CSR_XLEN-1:0] pc_q;
    int                   err_cnt;
    int                   chk_cnt;

    csr_unit_top uut (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .wb_i        (wb_i),
        .wb_xcpt_i   (wb_xcpt_i),
        .stall_exe_i (stall_exe_i),
        .csr_rdata_o (csr_rdata_o),
        .redirect_o  (redirect_o),
        .illegal_o   (illegal_o),
        .csr_req_o   (csr_req_o)
    );

    always #5 clk_i = ~clk_i;

    // value of one csr in the model, hit low for unknown addresses
    function automatic logic [`CSR_XLEN-1:0] model_read(input model_t s,
                                                         input logic [`CSR_ADDR_W-1:0] addr,
                                                         output logic hit);
        hit = 1'b1;
        case (addr)
            CSR_MSTATUS:  return {56'b0, s.mpie, 3'b000, s.mie, 3'b000};
            CSR_MTVEC:    return s.mtvec;
            CSR_MSCRATCH: return s.mscratch;
            CSR_MEPC:     return s.mepc;
            CSR_MCAUSE:   return s.mcause;
            CSR_MCYCLE:   return s.mcycle;
            CSR_MINSTRET: return s.minstret;
            default: begin
                hit = 1'b0;
                return '0;
            end
        endcase
    endfunction

    // one writeback cycle of the reference model, returns the state after the edge
    function automatic model_t ref_step(input model_t s, input exe_wb_instr_t w,
                                        input logic xcpt, input logic stall,
                                        output expect_t e);
        model_t                 n;
        logic                   is_rw;
        logic                   is_set;
        logic                   is_clr;
        logic                   is_sys;
        logic                   access;
        logic                   ena;
        logic                   hit;
        logic                   illegal;
        logic                   env;
        logic                   mret;
        logic                   trap;
        logic                   rs1_zero;
        logic [`CSR_ADDR_W-1:0] addr;
        logic [`CSR_XLEN-1:0]   wdata;
        logic [`CSR_XLEN-1:0]   cur;
        logic [`CSR_XLEN-1:0]   upd;
        logic [`CSR_XLEN-1:0]   cause;

        n        = s;
        is_rw    = w.valid && (w.instr_type inside {CSRRW, CSRRWI});
        is_set   = w.valid && (w.instr_type inside {CSRRS, CSRRSI});
        is_clr   = w.valid && (w.instr_type inside {CSRRC, CSRRCI});
        is_sys   = w.valid && (w.instr_type inside {ECALL, EBREAK, MRET, WFI, URET, SRET,
                                                    SFENCE_VMA, MRTS});
        access   = is_rw || is_set || is_clr;
        ena      = access || is_sys;
        rs1_zero = (w.rs1 == 5'd0);
        // disabled requests read address zero
        addr     = ena ? w.csr_addr : '0;
        if (w.instr_type inside {CSRRWI, CSRRSI, CSRRCI}) begin
            wdata = {59'b0, w.rs1};
        end else begin
            wdata = w.result;
        end
        cur     = model_read(s, addr, hit);
        illegal = access && !hit;
        env     = is_sys && (w.instr_type inside {ECALL, EBREAK});
        mret    = is_sys && (w.instr_type == MRET) && !xcpt;
        trap    = xcpt || illegal || env;

        // cause priority: pipe exception, illegal, ecall, ebreak
        if (xcpt) begin
            cause = w.ex.cause;
        end else if (illegal) begin
            cause = 64'(`CSR_CAUSE_ILLEGAL);
        end else if (w.instr_type == ECALL) begin
            cause = 64'(`CSR_CAUSE_ECALL_M);
        end else begin
            cause = 64'(`CSR_CAUSE_BREAKPOINT);
        end

        e.rdata       = cur;
        e.redir_valid = trap || mret;
        e.redir_pc    = trap ? s.mtvec : s.mepc;
        e.illegal     = illegal && !xcpt;

        // request as decoded from the writeback instruction
        e.req.csr_rw_addr = addr;
        if (!ena) begin
            e.req.csr_rw_cmd  = CSR_CMD_NOPE;
            e.req.csr_rw_data = w.ex.origin;
        end else if (is_sys) begin
            e.req.csr_rw_cmd  = CSR_CMD_SYS;
            e.req.csr_rw_data = '0;
        end else begin
            if (is_rw) begin
                e.req.csr_rw_cmd = CSR_CMD_WRITE;
            end else if (rs1_zero) begin
                e.req.csr_rw_cmd = CSR_CMD_READ;
            end else if (is_set) begin
                e.req.csr_rw_cmd = CSR_CMD_SET;
            end else begin
                e.req.csr_rw_cmd = CSR_CMD_CLEAR;
            end
            e.req.csr_rw_data = wdata;
        end
        e.req.csr_exception  = xcpt;
        e.req.csr_retire     = w.valid && !xcpt && !stall;
        e.req.csr_xcpt_cause = w.ex.cause;
        e.req.csr_pc         = w.pc;

        // mcycle runs even under stall
        n.mcycle = s.mcycle + 64'd1;
        if (!stall) begin
            if (w.valid && !trap) begin
                n.minstret = s.minstret + 64'd1;
            end
            if (trap) begin
                n.mepc   = w.pc;
                n.mcause = cause;
                n.mpie   = s.mie;
                n.mie    = 1'b0;
            end else if (mret) begin
                n.mie  = s.mpie;
                n.mpie = 1'b1;
            end else if (access && !((is_set || is_clr) && rs1_zero)) begin
                if (is_rw) begin
                    upd = wdata;
                end else if (is_set) begin
                    upd = cur | wdata;
                end else begin
                    upd = cur & ~wdata;
                end
                // a software write to a counter wins over its increment
                case (addr)
                    CSR_MSTATUS: begin
                        n.mie  = upd[3];
                        n.mpie = upd[7];
                    end
                    CSR_MTVEC:    n.mtvec    = {upd[63:2], 2'b00};
                    CSR_MSCRATCH: n.mscratch = upd;
                    CSR_MEPC:     n.mepc     = upd;
                    CSR_MCAUSE:   n.mcause   = upd;
                    CSR_MCYCLE:   n.mcycle   = upd;
                    CSR_MINSTRET: n.minstret = upd;
                    default: begin
                    end
                endcase
            end
        end
        return n;
    endfunction

    task automatic check(input logic [`CSR_XLEN-1:0] got, input logic [`CSR_XLEN-1:0] exp,
                         input string what);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // one instruction per rising edge
    task automatic issue(input instr_type_t t, input logic [`CSR_ADDR_W-1:0] addr,
                         input logic [4:0] rs1, input logic [`CSR_XLEN-1:0] value,
                         input logic xcpt, input logic [`CSR_XLEN-1:0] cause,
                         input logic stall);
        exe_wb_instr_t w;
        w.valid      = 1'b1;
        w.pc         = pc_q;
        w.instr_type = t;
        w.rs1        = rs1;
        w.csr_addr   = addr;
        w.result     = value;
        w.ex.cause   = xcpt ? cause : '0;
        w.ex.origin  = {$urandom, $urandom};
        pc_q         = pc_q + 64'd4;
        @(posedge clk_i);
        wb_i        <= w;
        wb_xcpt_i   <= xcpt;
        stall_exe_i <= stall;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk_i);
            wb_i        <= '0;
            wb_xcpt_i   <= 1'b0;
            stall_exe_i <= 1'b0;
        end
    endtask

    // mostly implemented addresses, some random ones for illegal accesses
    function automatic logic [`CSR_ADDR_W-1:0] random_addr(input int sel);
        case (sel)
            0: return CSR_MSTATUS;
            1: return CSR_MTVEC;
            2: return CSR_MSCRATCH;
            3: return CSR_MEPC;
            4: return CSR_MCAUSE;
            5: return CSR_MCYCLE;
            6: return CSR_MINSTRET;
            default: return 12'($urandom);
        endcase
    endfunction

    // compare on the falling edge, then advance the model
    always @(negedge clk_i) begin
        if (!rst_n_i) begin
            model_q = '0;
        end else begin
            model_nxt = ref_step(model_q, wb_i, wb_xcpt_i, stall_exe_i, exp_s);
            check(csr_rdata_o, exp_s.rdata, "csr read data");
            check(64'(redirect_o.valid), 64'(exp_s.redir_valid), "redirect valid");
            if (exp_s.redir_valid) begin
                check(redirect_o.pc, exp_s.redir_pc, "redirect pc");
            end
            check(64'(illegal_o), 64'(exp_s.illegal), "illegal flag");
            check(64'(csr_req_o.csr_rw_addr), 64'(exp_s.req.csr_rw_addr), "request address");
            check(64'(csr_req_o.csr_rw_cmd), 64'(exp_s.req.csr_rw_cmd), "request command");
            check(csr_req_o.csr_rw_data, exp_s.req.csr_rw_data, "request data");
            check(64'(csr_req_o.csr_exception), 64'(exp_s.req.csr_exception),
                  "request exception");
            check(64'(csr_req_o.csr_retire), 64'(exp_s.req.csr_retire), "request retire");
            check(csr_req_o.csr_xcpt_cause, exp_s.req.csr_xcpt_cause, "request cause");
            check(csr_req_o.csr_pc, exp_s.req.csr_pc, "request pc");
            model_q = model_nxt;
        end
    end

    initial begin
        #(10 * (N_INSTR + 100));
        $display("timeout: the run did not finish within %0d cycles", N_INSTR + 100);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        instr_type_t t;
        logic        xcpt;
        logic        stall;
        logic [4:0]  rs1;

        void'($urandom(32'hf1f7_b999));
        clk_i       = 1'b0;
        rst_n_i     = 1'b0;
        wb_i        = '0;
        wb_xcpt_i   = 1'b0;
        stall_exe_i = 1'b0;
        pc_q        = 64'h0000_0000_8000_0000;
        err_cnt     = 0;
        chk_cnt     = 0;
        repeat (16) @(posedge clk_i);
        rst_n_i <= 1'b1;

        // csrrw and csrrwi, then read back
        issue(CSRRW,  CSR_MSCRATCH, 5'd1, 64'hdead_beef_0123_4567, 1'b0, '0, 1'b0);
        issue(CSRRS,  CSR_MSCRATCH, 5'd0, '0, 1'b0, '0, 1'b0);
        issue(CSRRWI, CSR_MTVEC, 5'h13, '0, 1'b0, '0, 1'b0);
        issue(CSRRS,  CSR_MTVEC, 5'd0, '0, 1'b0, '0, 1'b0);
        issue(CSRRW,  CSR_MTVEC, 5'd2, 64'h0000_0000_8000_1003, 1'b0, '0, 1'b0);
        issue(CSRRW,  CSR_MEPC, 5'd3, 64'h0000_0000_0000_2468, 1'b0, '0, 1'b0);
        issue(CSRRS,  CSR_MTVEC, 5'd0, '0, 1'b0, '0, 1'b0);
        issue(CSRRS,  CSR_MEPC, 5'd0, '0, 1'b0, '0, 1'b0);
        // set and clear, rs1 zero leaves the value alone
        issue(CSRRS,  CSR_MSCRATCH, 5'd4, 64'h0000_f0f0_0000_f0f0, 1'b0, '0, 1'b0);
        issue(CSRRC,  CSR_MSCRATCH, 5'd5, 64'hffff_0000_0000_0000, 1'b0, '0, 1'b0);
        issue(CSRRSI, CSR_MSCRATCH, 5'h1f, '0, 1'b0, '0, 1'b0);
        issue(CSRRCI, CSR_MSCRATCH, 5'h05, '0, 1'b0, '0, 1'b0);
        issue(CSRRCI, CSR_MSCRATCH, 5'd0, '0, 1'b0, '0, 1'b0);
        issue(CSRRC,  CSR_MSCRATCH, 5'd0, '1, 1'b0, '0, 1'b0);
        issue(CSRRS,  CSR_MSCRATCH, 5'd0, '0, 1'b0, '0, 1'b0);
        // ecall with mie set, then mret
        issue(CSRRSI, CSR_MSTATUS, 5'h08, '0, 1'b0, '0, 1'b0);
        issue(ECALL,  12'h000, 5'd0, '0, 1'b0, '0, 1'b0);
        issue(CSRRS,  CSR_MEPC, 5'd0, '0, 1'b0, '0, 1'b0);
        issue(CSRRS,  CSR_MCAUSE, 5'd0, '0, 1'b0, '0, 1'b0);
        issue(CSRRS,  CSR_MSTATUS, 5'd0, '0, 1'b0, '0, 1'b0);
        issue(MRET,   12'h000, 5'd0, '0, 1'b0, '0, 1'b0);
        issue(CSRRS,  CSR_MSTATUS, 5'd0, '0, 1'b0, '0, 1'b0);
        issue(EBREAK, 12'h000, 5'd0, '0, 1'b0, '0, 1'b0);
        issue(CSRRS,  CSR_MCAUSE, 5'd0, '0, 1'b0, '0, 1'b0);
        // exception from the pipe
        issue(OTHER,  12'h000, 5'd0, '0, 1'b1, 64'd5, 1'b0);
        issue(CSRRS,  CSR_MCAUSE, 5'd0, '0, 1'b0, '0, 1'b0);
        issue(MRET,   12'h000, 5'd0, '0, 1'b0, '0, 1'b0);
        // unknown addresses trap with no write
        issue(CSRRW,  12'h7c0, 5'd1, 64'h1111_2222_3333_4444, 1'b0, '0, 1'b0);
        issue(CSRRS,  12'h123, 5'd0, '0, 1'b0, '0, 1'b0);
        issue(CSRRS,  CSR_MCAUSE, 5'd0, '0, 1'b0, '0, 1'b0);
        // stalled write and ecall change nothing
        issue(CSRRW,  CSR_MSCRATCH, 5'd1, 64'h5555_aaaa_5555_aaaa, 1'b0, '0, 1'b1);
        issue(ECALL,  12'h000, 5'd0, '0, 1'b0, '0, 1'b1);

        for (int i = 0; i < N_RANDOM; i++) begin
            t     = instr_type_t'(4'($urandom_range(0, 14)));
            rs1   = ($urandom_range(0, 3) == 0) ? 5'd0 : 5'($urandom);
            xcpt  = ($urandom_range(0, 9) == 0);
            stall = ($urandom_range(0, 7) == 0);
            issue(t, random_addr(int'($urandom_range(0, 7))), rs1, {$urandom, $urandom},
                  xcpt, 64'($urandom_range(0, 15)), stall);
        end

        // counters after the random run
        issue(CSRRS, CSR_MINSTRET, 5'd0, '0, 1'b0, '0, 1'b0);
        issue(CSRRS, CSR_MCYCLE, 5'd0, '0, 1'b0, '0, 1'b0);
        issue(CSRRS, CSR_MCYCLE, 5'd0, '0, 1'b0, '0, 1'b0);
        idle(3);
        @(negedge clk_i);

        $display("errors: %0d of %0d checks", err_cnt, chk_cnt);
        if (err_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
